//--- Makefile
# Verilator flow for the JTAG TAP testbench, run from the project root

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module jtag_tb

run: compile
	./obj_dir/Vjtag_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
+incdir+common
common/jtag_pkg.sv
common/jtag_dr_if.sv
tap/jtag_tap_fsm.sv
tap/jtag_ir_chain.sv
design/jtag_data_reg.sv
design/jtag_tap_top.sv
tests/jtag_sva.sv
tests/jtag_checker.sv
tests/jtag_tb.sv

//--- common/jtag_defs.svh
/*
 * Fixed JTAG constants shared by the TAP design.
 * Include wherever the instruction width, instruction codes, select bit
 * positions or the IDCODE value are needed.
 */
`ifndef JTAG_DEFS_SVH
`define JTAG_DEFS_SVH

// Instruction register width
`define JTAG_IR_W 4

// Instruction codes, anything unlisted decodes as BYPASS
`define JTAG_IR_IDCODE 4'b0001
`define JTAG_IR_DR0    4'b0010
`define JTAG_IR_DR1    4'b0011
`define JTAG_IR_BYPASS 4'b1111

// Pattern loaded into the IR shift stage in Capture-IR
`define JTAG_IR_CAPTURE 4'b0001

// Identification value, bit 0 must stay set per IEEE 1149.1
`define JTAG_IDCODE 32'h1E57_A0B3

// One-hot data register select, bit positions
`define JTAG_SEL_W      4
`define JTAG_SEL_DR0    0
`define JTAG_SEL_DR1    1
`define JTAG_SEL_IDCODE 2
`define JTAG_SEL_BYPASS 3

`endif

//--- common/jtag_dr_if.sv
/*
 * Data register control bundle of the TAP.
 * The controller drives the DR strobes and the scan input, the instruction
 * chain drives the one-hot register select, data registers listen.
 */
`include "jtag_defs.svh"

interface jtag_dr_if;

    // High for the whole cycle spent in the matching TAP state
    logic capture_dr;
    logic shift_dr;
    logic update_dr;

    // TDI as seen by every data register
    logic scan_in;

    // One bit per data register, see the JTAG_SEL_* positions
    logic [`JTAG_SEL_W-1:0] tdo_sel;

    modport ctrl (
        output capture_dr,
        output shift_dr,
        output update_dr,
        output scan_in
    );

    modport decode (
        input  capture_dr,
        input  shift_dr,
        output tdo_sel
    );

    modport dreg (
        input capture_dr,
        input shift_dr,
        input update_dr,
        input scan_in
    );

endinterface

//--- common/jtag_pkg.sv
/*
 * Types for the JTAG TAP subsystem: controller states, instructions and
 * the payloads of the two user data registers.
 * Referenced by scoped name from the RTL and the assertions.
 */
`include "jtag_defs.svh"

package jtag_pkg;

    // Standard 1149.1 state encoding
    typedef enum logic [3:0] {
        ts_exit2_dr          = 4'h0,
        ts_exit1_dr          = 4'h1,
        ts_shift_dr          = 4'h2,
        ts_pause_dr          = 4'h3,
        ts_select_ir         = 4'h4,
        ts_update_dr         = 4'h5,
        ts_capture_dr        = 4'h6,
        ts_select_dr         = 4'h7,
        ts_exit2_ir          = 4'h8,
        ts_exit1_ir          = 4'h9,
        ts_shift_ir          = 4'hA,
        ts_pause_ir          = 4'hB,
        ts_run_test_idle     = 4'hC,
        ts_update_ir         = 4'hD,
        ts_capture_ir        = 4'hE,
        ts_test_logic_reset  = 4'hF
    } tap_state_e;

    // Known instructions; other codes are left unnamed and act as BYPASS
    typedef enum logic [`JTAG_IR_W-1:0] {
        instr_idcode = `JTAG_IR_IDCODE,
        instr_dr0    = `JTAG_IR_DR0,
        instr_dr1    = `JTAG_IR_DR1,
        instr_bypass = `JTAG_IR_BYPASS
    } jtag_instr_e;

    // User register 0, control word driven to the system
    typedef struct packed {
        logic [7:0] mode;
        logic [7:0] cmd;
    } ctrl_reg_t;

    // User register 1, status captured from the system plus a data half
    typedef struct packed {
        logic [15:0] status;
        logic [15:0] data;
    } data_reg_t;

endpackage

//--- design/jtag_data_reg.sv
/*
 * Generic JTAG data register with capture, shift and update stages.
 * The payload type sets the width; instantiated once per user register
 * with its select bit from the instruction decode.
 */
module jtag_data_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     tck_i,
    input  logic     reset_i,
    input  logic     enable_i,
    input  logic     sel_i,
    jtag_dr_if.dreg  dr,
    input  payload_t par_i,
    output payload_t par_o,
    output logic     so_o,
    output logic     set_o
);

    localparam int W = $bits(payload_t);

    logic [W-1:0] shift_q;
    logic [W-1:0] upd_q;
    logic [W-1:0] cap_val;

    // Live parallel input when enabled, otherwise recirculate
    assign cap_val = enable_i ? W'(par_i) : upd_q;

    // Shift stage, LSB leaves first and TDI enters at the MSB
    always_ff @(posedge tck_i) begin
        if (sel_i) begin
            if (dr.capture_dr) begin
                shift_q <= cap_val;
            end else if (dr.shift_dr) begin
                shift_q <= {dr.scan_in, shift_q[W-1:1]};
            end
        end
    end

    // Update stage takes the shifted word on the edge leaving Update-DR
    always_ff @(posedge tck_i) begin
        if (reset_i || !enable_i) begin
            upd_q <= '0;
        end else if (sel_i && dr.update_dr) begin
            upd_q <= shift_q;
        end
    end

    assign par_o = payload_t'(upd_q);
    assign so_o  = shift_q[0];

    // One TCK cycle, coincides with the update load
    assign set_o = sel_i & dr.update_dr;

endmodule

//--- design/jtag_tap_top.sv
/*
 * JTAG TAP subsystem top level, everything clocked by TCK.
 * User register 0 drives a 16-bit control word, user register 1 captures
 * a 32-bit status word; each pulses its set output on update.
 */
module jtag_tap_top (
    input  logic                tck_i,
    input  logic                reset_i,
    input  logic                enable_i,
    input  logic                tms_i,
    input  logic                tdi_i,
    output logic                tdo_o,
    output jtag_pkg::ctrl_reg_t ctrl_o,
    output logic                ctrl_set_o,
    input  jtag_pkg::data_reg_t data_i,
    output jtag_pkg::data_reg_t data_o,
    output logic                data_set_o
);

    // IR path strobes
    logic capture_ir;
    logic shift_ir;
    logic update_ir;

    // User register selects and serial outputs
    logic [1:0] user_sel;
    logic       dr0_so;
    logic       dr1_so;

    jtag_dr_if dr_if ();

    jtag_tap_fsm u_fsm (
        .tck_i        (tck_i),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .tms_i        (tms_i),
        .tdi_i        (tdi_i),
        .dr           (dr_if.ctrl),
        .capture_ir_o (capture_ir),
        .shift_ir_o   (shift_ir),
        .update_ir_o  (update_ir),
        // State is observed inside the controller only
        .state_o      ()
    );

    jtag_ir_chain u_ir (
        .tck_i        (tck_i),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .tdi_i        (tdi_i),
        .capture_ir_i (capture_ir),
        .shift_ir_i   (shift_ir),
        .update_ir_i  (update_ir),
        .dr           (dr_if.decode),
        .dr0_so_i     (dr0_so),
        .dr1_so_i     (dr1_so),
        .tdo_o        (tdo_o),
        .sel_o        (user_sel)
    );

    // Control register captures its own update value
    jtag_data_reg #(.payload_t(jtag_pkg::ctrl_reg_t)) u_dr0 (
        .tck_i    (tck_i),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .sel_i    (user_sel[0]),
        .dr       (dr_if.dreg),
        .par_i    (ctrl_o),
        .par_o    (ctrl_o),
        .so_o     (dr0_so),
        .set_o    (ctrl_set_o)
    );

    // Status/data register samples the system input
    jtag_data_reg #(.payload_t(jtag_pkg::data_reg_t)) u_dr1 (
        .tck_i    (tck_i),
        .reset_i  (reset_i),
        .enable_i (enable_i),
        .sel_i    (user_sel[1]),
        .dr       (dr_if.dreg),
        .par_i    (data_i),
        .par_o    (data_o),
        .so_o     (dr1_so),
        .set_o    (data_set_o)
    );

endmodule

//--- tap/jtag_ir_chain.sv
/*
 * Instruction register with decode to a one-hot DR select, plus the
 * BYPASS and IDCODE registers and the combinational TDO multiplexer.
 * User register serial outputs come in from the top level.
 */
`include "jtag_defs.svh"

module jtag_ir_chain (
    input  logic       tck_i,
    input  logic       reset_i,
    input  logic       enable_i,
    input  logic       tdi_i,
    input  logic       capture_ir_i,
    input  logic       shift_ir_i,
    input  logic       update_ir_i,
    jtag_dr_if.decode  dr,
    input  logic       dr0_so_i,
    input  logic       dr1_so_i,
    output logic       tdo_o,
    output logic [1:0] sel_o
);

    logic [`JTAG_IR_W-1:0] ir_sr;
    jtag_pkg::jtag_instr_e ir_q;
    logic                  bypass_q;
    logic [31:0]           idcode_sr;
    logic                  dr_so;

    // IR shift stage, TDI enters at the MSB
    always_ff @(posedge tck_i) begin
        if (capture_ir_i) begin
            ir_sr <= `JTAG_IR_CAPTURE;
        end else if (shift_ir_i) begin
            ir_sr <= {tdi_i, ir_sr[`JTAG_IR_W-1:1]};
        end
    end

    // IR update stage, IDCODE after any reset
    always_ff @(posedge tck_i) begin
        if (reset_i || !enable_i) begin
            ir_q <= jtag_pkg::instr_idcode;
        end else if (update_ir_i) begin
            ir_q <= jtag_pkg::jtag_instr_e'(ir_sr);
        end
    end

    // Instruction to one-hot select; unknown codes fall back to BYPASS
    always_comb begin
        dr.tdo_sel = '0;
        case (ir_q)
            jtag_pkg::instr_idcode: dr.tdo_sel[`JTAG_SEL_IDCODE] = 1'b1;
            jtag_pkg::instr_dr0:    dr.tdo_sel[`JTAG_SEL_DR0] = 1'b1;
            jtag_pkg::instr_dr1:    dr.tdo_sel[`JTAG_SEL_DR1] = 1'b1;
            default:                dr.tdo_sel[`JTAG_SEL_BYPASS] = 1'b1;
        endcase
    end

    assign sel_o = {dr.tdo_sel[`JTAG_SEL_DR1], dr.tdo_sel[`JTAG_SEL_DR0]};

    // Single-bit BYPASS, captures zero
    always_ff @(posedge tck_i) begin
        if (dr.tdo_sel[`JTAG_SEL_BYPASS]) begin
            if (dr.capture_dr) begin
                bypass_q <= 1'b0;
            end else if (dr.shift_dr) begin
                bypass_q <= tdi_i;
            end
        end
    end

    // IDCODE is capture and shift only, no update stage
    always_ff @(posedge tck_i) begin
        if (dr.tdo_sel[`JTAG_SEL_IDCODE]) begin
            if (dr.capture_dr) begin
                idcode_sr <= `JTAG_IDCODE;
            end else if (dr.shift_dr) begin
                idcode_sr <= {tdi_i, idcode_sr[31:1]};
            end
        end
    end

    // Serial output of whichever DR is selected
    always_comb begin
        dr_so = 1'b0;
        if (dr.tdo_sel[`JTAG_SEL_DR0]) dr_so = dr0_so_i;
        if (dr.tdo_sel[`JTAG_SEL_DR1]) dr_so = dr1_so_i;
        if (dr.tdo_sel[`JTAG_SEL_IDCODE]) dr_so = idcode_sr[0];
        if (dr.tdo_sel[`JTAG_SEL_BYPASS]) dr_so = bypass_q;
    end

    // Low outside the two shift states
    assign tdo_o = shift_ir_i  ? ir_sr[0] :
                   dr.shift_dr ? dr_so    : 1'b0;

endmodule

//--- tap/jtag_tap_fsm.sv
/*
 * IEEE 1149.1 TAP controller, advanced by TMS on each rising TCK edge.
 * Decodes the Capture/Shift/Update strobes for the IR and DR paths and
 * passes TDI onto the data register bundle.
 */
module jtag_tap_fsm (
    input  logic                 tck_i,
    input  logic                 reset_i,
    input  logic                 enable_i,
    input  logic                 tms_i,
    input  logic                 tdi_i,
    jtag_dr_if.ctrl              dr,
    output logic                 capture_ir_o,
    output logic                 shift_ir_o,
    output logic                 update_ir_o,
    output jtag_pkg::tap_state_e state_o
);

    jtag_pkg::tap_state_e state_q;
    jtag_pkg::tap_state_e state_d;

    // Next state from TMS, standard sixteen-state graph
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            jtag_pkg::ts_test_logic_reset:
                state_d = tms_i ? jtag_pkg::ts_test_logic_reset : jtag_pkg::ts_run_test_idle;
            jtag_pkg::ts_run_test_idle:
                state_d = tms_i ? jtag_pkg::ts_select_dr : jtag_pkg::ts_run_test_idle;
            // DR column
            jtag_pkg::ts_select_dr:
                state_d = tms_i ? jtag_pkg::ts_select_ir : jtag_pkg::ts_capture_dr;
            jtag_pkg::ts_capture_dr:
                state_d = tms_i ? jtag_pkg::ts_exit1_dr : jtag_pkg::ts_shift_dr;
            jtag_pkg::ts_shift_dr:
                state_d = tms_i ? jtag_pkg::ts_exit1_dr : jtag_pkg::ts_shift_dr;
            jtag_pkg::ts_exit1_dr:
                state_d = tms_i ? jtag_pkg::ts_update_dr : jtag_pkg::ts_pause_dr;
            jtag_pkg::ts_pause_dr:
                state_d = tms_i ? jtag_pkg::ts_exit2_dr : jtag_pkg::ts_pause_dr;
            jtag_pkg::ts_exit2_dr:
                state_d = tms_i ? jtag_pkg::ts_update_dr : jtag_pkg::ts_shift_dr;
            jtag_pkg::ts_update_dr:
                state_d = tms_i ? jtag_pkg::ts_select_dr : jtag_pkg::ts_run_test_idle;
            // IR column
            jtag_pkg::ts_select_ir:
                state_d = tms_i ? jtag_pkg::ts_test_logic_reset : jtag_pkg::ts_capture_ir;
            jtag_pkg::ts_capture_ir:
                state_d = tms_i ? jtag_pkg::ts_exit1_ir : jtag_pkg::ts_shift_ir;
            jtag_pkg::ts_shift_ir:
                state_d = tms_i ? jtag_pkg::ts_exit1_ir : jtag_pkg::ts_shift_ir;
            jtag_pkg::ts_exit1_ir:
                state_d = tms_i ? jtag_pkg::ts_update_ir : jtag_pkg::ts_pause_ir;
            jtag_pkg::ts_pause_ir:
                state_d = tms_i ? jtag_pkg::ts_exit2_ir : jtag_pkg::ts_pause_ir;
            jtag_pkg::ts_exit2_ir:
                state_d = tms_i ? jtag_pkg::ts_update_ir : jtag_pkg::ts_shift_ir;
            jtag_pkg::ts_update_ir:
                state_d = tms_i ? jtag_pkg::ts_select_dr : jtag_pkg::ts_run_test_idle;
            default:
                state_d = jtag_pkg::ts_test_logic_reset;
        endcase
    end

    // Disable acts like a held TRST
    always_ff @(posedge tck_i) begin
        if (reset_i || !enable_i) begin
            state_q <= jtag_pkg::ts_test_logic_reset;
        end else begin
            state_q <= state_d;
        end
    end

    // DR strobes onto the shared bundle
    assign dr.capture_dr = (state_q == jtag_pkg::ts_capture_dr);
    assign dr.shift_dr   = (state_q == jtag_pkg::ts_shift_dr);
    assign dr.update_dr  = (state_q == jtag_pkg::ts_update_dr);
    assign dr.scan_in    = tdi_i;

    // IR strobes go straight to the instruction chain
    assign capture_ir_o = (state_q == jtag_pkg::ts_capture_ir);
    assign shift_ir_o   = (state_q == jtag_pkg::ts_shift_ir);
    assign update_ir_o  = (state_q == jtag_pkg::ts_update_ir);

    assign state_o = state_q;

endmodule

//--- tests/jtag_checker.sv
/*
 * Scoreboard for the JTAG testbench.
 * Assembles TDO over each Shift-IR/Shift-DR cycle, counts set pulses and
 * compares them and the parallel outputs with golden values on request.
 */
module jtag_checker (
    input logic                 tck_i,
    input jtag_pkg::tap_state_e state_i,
    input logic                 tdo_i,
    input jtag_pkg::ctrl_reg_t  ctrl_i,
    input logic                 ctrl_set_i,
    input jtag_pkg::data_reg_t  data_i,
    input logic                 data_set_i
);

    logic [63:0] shifted;
    int          bit_cnt;
    int          ctrl_pulses;
    int          data_pulses;
    int          check_cnt = 0;
    int          err_cnt = 0;

    // TDO and the strobes are stable mid-cycle
    always @(negedge tck_i) begin
        if (state_i == jtag_pkg::ts_shift_dr || state_i == jtag_pkg::ts_shift_ir) begin
            if (bit_cnt < 64) shifted[bit_cnt] = tdo_i;
            bit_cnt++;
        end
        if (ctrl_set_i) ctrl_pulses++;
        if (data_set_i) data_pulses++;
    end

    task automatic begin_op();
        shifted = '0;
        bit_cnt = 0;
        ctrl_pulses = 0;
        data_pulses = 0;
    endtask

    task automatic compare(input string name, input string what,
                           input logic [63:0] exp, input logic [63:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("error %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_op(input string name, input string op, input int len,
                            input logic [63:0] exp_out, input logic [63:0] exp_par);
        logic [63:0] mask;
        mask = (len >= 64) ? '1 : ((64'd1 << len) - 64'd1);
        if (op == "RESET" || op == "DISABLE") begin
            // Both update stages cleared
            compare(name, "ctrl_o", exp_par & 64'hFFFF, 64'(ctrl_i));
            compare(name, "data_o", exp_par, 64'(data_i));
            return;
        end
        compare(name, "tdo", exp_out & mask, shifted & mask);
        if (op == "DRC" || op == "ABORT") begin
            compare(name, "ctrl_o", exp_par, 64'(ctrl_i));
            compare(name, "ctrl_set pulses", 64'd1, 64'(ctrl_pulses));
        end
        if (op == "DRD") begin
            compare(name, "data_o", exp_par, 64'(data_i));
            compare(name, "data_set pulses", 64'd1, 64'(data_pulses));
        end
    endtask

endmodule

//--- tests/jtag_golden.txt
# name op len shift_in expected_tdo expected_parallel data_i
# len is decimal, the other values are hex, bits go LSB first
rst0 RESET 0 0 0 0 0
idcode_dr DR 32 0 1e57a0b3 0 0
idcode_ir IR 4 1 1 0 0
byp_ir IR 4 f 1 0 0
byp_dr DR 8 a5 4a 0 0
unk_ir IR 4 5 1 0 0
unk_dr DR 8 3c 78 0 0
dr0_ir IR 4 2 1 0 0
dr0_wr1 DRC 16 beef 0 beef 0
dr0_wr2 DRC 16 1234 beef 1234 0
dr1_ir IR 4 3 1 0 0
dr1_cap DRD 32 12345678 cafe0042 12345678 cafe0042
dr1_cap2 DRD 32 0 5a5a0001 0 5a5a0001
dis DISABLE 0 0 0 0 0
dis_dr DR 32 0 1e57a0b3 0 0
dis_ir IR 4 2 1 0 0
tms_wr DRC 16 00a5 0 00a5 0
tms_abort ABORT 8 ff a5 7f80 0
tms_ir IR 4 1 1 0 0
tms_dr DR 32 0 1e57a0b3 0 0

//--- tests/jtag_sva.sv
/*
 * Assertions on the TAP controller, bound into jtag_tap_fsm.
 * Covers strobe exclusivity, reset entry and the five-TMS reset path.
 */
module jtag_sva (
    input logic                 tck_i,
    input logic                 reset_i,
    input logic                 tms_i,
    input logic                 capture_ir_i,
    input logic                 shift_ir_i,
    input logic                 update_ir_i,
    input logic                 capture_dr_i,
    input logic                 shift_dr_i,
    input logic                 update_dr_i,
    input jtag_pkg::tap_state_e state_i
);

    // IR strobes and the DR strobes on the shared bundle
    strobe_onehot: assert property (@(posedge tck_i) disable iff (reset_i)
        $onehot0({capture_ir_i, shift_ir_i, update_ir_i,
                  capture_dr_i, shift_dr_i, update_dr_i}))
        else $error("more than one TAP strobe high");

    reset_tlr: assert property (@(posedge tck_i)
        reset_i |=> state_i == jtag_pkg::ts_test_logic_reset)
        else $error("TAP not in Test-Logic-Reset after reset");

    tms_tlr: assert property (@(posedge tck_i)
        tms_i [*5] |=> state_i == jtag_pkg::ts_test_logic_reset)
        else $error("TAP not in Test-Logic-Reset after five TMS-high cycles");

endmodule

//--- tests/jtag_tb.sv
/*
 * Testbench top for the JTAG TAP subsystem.
 * Reads operations from the golden file, sequences TMS/TDI from Run-Test/Idle
 * and hands each operation to the checker for comparison.
 */
module jtag_tb;

    logic                tck;
    logic                reset;
    logic                enable;
    logic                tms;
    logic                tdi;
    logic                tdo;
    jtag_pkg::ctrl_reg_t ctrl;
    logic                ctrl_set;
    jtag_pkg::data_reg_t data_in;
    jtag_pkg::data_reg_t data_out;
    logic                data_set;

    jtag_tap_top uut (
        .tck_i      (tck),
        .reset_i    (reset),
        .enable_i   (enable),
        .tms_i      (tms),
        .tdi_i      (tdi),
        .tdo_o      (tdo),
        .ctrl_o     (ctrl),
        .ctrl_set_o (ctrl_set),
        .data_i     (data_in),
        .data_o     (data_out),
        .data_set_o (data_set)
    );

    // Watches the controller state to find the shift cycles
    jtag_checker chk (
        .tck_i      (tck),
        .state_i    (uut.u_fsm.state_o),
        .tdo_i      (tdo),
        .ctrl_i     (ctrl),
        .ctrl_set_i (ctrl_set),
        .data_i     (data_out),
        .data_set_i (data_set)
    );

    // TCK, period 20
    initial tck = 1'b0;
    always #10 tck = ~tck;

    // Values take effect at the following rising edge
    task automatic drive(input logic tms_v, input logic tdi_v);
        @(posedge tck);
        #2;
        tms = tms_v;
        tdi = tdi_v;
    endtask

    // Hold reset_i or drop enable_i, then walk to Run-Test/Idle
    task automatic tap_reset(input int cycles, input logic use_enable);
        @(posedge tck);
        #2;
        if (use_enable) enable = 1'b0;
        else reset = 1'b1;
        tms = 1'b1;
        repeat (cycles) @(posedge tck);
        #2;
        reset = 1'b0;
        enable = 1'b1;
        tms = 1'b0;
        @(posedge tck);
        #2;
    endtask

    // Select-DR, optionally Select-IR, Capture, then len shift bits
    task automatic scan(input logic is_ir, input int len, input logic [63:0] bits,
                        input logic abort);
        drive(1'b1, 1'b0);
        if (is_ir) drive(1'b1, 1'b0);
        drive(1'b0, 1'b0);
        drive(1'b0, 1'b0);
        for (int i = 0; i < len; i++) begin
            drive(!abort && (i == len - 1), bits[i]);
        end
        if (abort) begin
            // Five TMS-high edges reach Test-Logic-Reset from Shift-DR
            repeat (5) drive(1'b1, 1'b0);
        end else begin
            drive(1'b1, 1'b0);
        end
        drive(1'b0, 1'b0);
    endtask

    // Poll on the rising edge until the checker has seen a set pulse
    task automatic wait_set(input string name);
        int n;
        n = 0;
        while (chk.ctrl_pulses + chk.data_pulses == 0) begin
            @(posedge tck);
            n++;
            if (n > 8) begin
                $display("timeout waiting for a set strobe in %s", name);
                $display("=== FAIL ===");
                $finish;
            end
        end
    endtask

    initial begin
        int          fd;
        int          cnt;
        string       line;
        string       name;
        string       op;
        int          len;
        logic [63:0] bits;
        logic [63:0] exp_out;
        logic [63:0] exp_par;
        logic [31:0] din;
        reset = 1'b1;
        enable = 1'b1;
        tms = 1'b1;
        tdi = 1'b0;
        data_in = '0;
        tap_reset(4, 1'b0);
        fd = $fopen("tests/jtag_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file");
            $display("=== FAIL ===");
            $finish;
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") continue;
            cnt = $sscanf(line, "%s %s %d %h %h %h %h",
                          name, op, len, bits, exp_out, exp_par, din);
            // Parallel input for this operation, set just after a rising edge
            @(posedge tck);
            #2;
            data_in = jtag_pkg::data_reg_t'(din);
            chk.begin_op();
            if (op == "RESET") tap_reset(4, 1'b0);
            else if (op == "DISABLE") tap_reset(1, 1'b1);
            else if (op == "IR") scan(1'b1, len, bits, 1'b0);
            else if (op == "ABORT") scan(1'b0, len, bits, 1'b1);
            else scan(1'b0, len, bits, 1'b0);
            if (op == "DRC" || op == "DRD" || op == "ABORT") wait_set(name);
            @(posedge tck);
            @(negedge tck);
            chk.check_op(name, op, len, exp_out, exp_par);
        end
        $fclose(fd);
        $display("checks %0d errors %0d", chk.check_cnt, chk.err_cnt);
        if (chk.err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Last resort if the sequencer stalls
    initial begin
        #200000;
        $display("simulation watchdog expired");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

bind jtag_tap_fsm jtag_sva u_sva (
    .tck_i        (tck_i),
    .reset_i      (reset_i),
    .tms_i        (tms_i),
    .capture_ir_i (capture_ir_o),
    .shift_ir_i   (shift_ir_o),
    .update_ir_i  (update_ir_o),
    .capture_dr_i (dr.capture_dr),
    .shift_dr_i   (dr.shift_dr),
    .update_dr_i  (dr.update_dr),
    .state_i      (state_o)
);
